/* src/apb_port.sv */
module apb_port (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::apb_req_s apb,
    output bus_pkg::mem_req_s apb_mem_req,
    input  logic              apb_gnt,
    input  logic [31:0]       rdata,
    output logic [31:0]       prdata,
    output logic              pready
);

    logic access;
    logic rd_done;

    assign access = apb.psel && apb.penable;

    always_comb begin
        apb_mem_req.valid = access && !rd_done;
        apb_mem_req.write = apb.pwrite;
        apb_mem_req.addr  = apb.paddr[11:2];
        apb_mem_req.wdata = apb.pwdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_done <= 1'b0;
        end else if (rd_done || !access) begin
            rd_done <= 1'b0;  // access ended.
        end else if (!apb.pwrite && apb_gnt) begin
            rd_done <= 1'b1;
        end
    end

    assign pready = (access && apb.pwrite && apb_gnt) || rd_done;
    assign prdata = rdata;

endmodule

/* src/bus_pkg.sv */
package bus_pkg;

    localparam int DATA_W     = 32;
    localparam int MEM_WORDS  = 1024;
    localparam int MEM_ADDR_W = 10;

    // internal valid/grant request.
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [MEM_ADDR_W-1:0] addr;   // word index.
        logic [DATA_W-1:0]     wdata;
    } mem_req_s;

    // apb inputs, paddr is a byte address.
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [11:0]       paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_s;

endpackage

/* src/controller.sv */
module controller (
    input  mips_pkg::opcode_e opcode,
    input  mips_pkg::funct_e  funct,
    input  logic              zero,
    output mips_pkg::ctrl_s   ctrl,
    output logic              illegal
);
    import mips_pkg::*;

    always_comb begin
        ctrl    = CTRL_NONE;
        illegal = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: begin
                        ctrl.reg_dst = DST_RD;
                        ctrl.reg_wr  = 1'b1;
                        ctrl.alu_op  = ALU_ADD;
                    end
                    FN_SUBU: begin
                        ctrl.reg_dst = DST_RD;
                        ctrl.reg_wr  = 1'b1;
                        ctrl.alu_op  = ALU_SUB;
                    end
                    default: illegal = 1'b1;  // slt, jr and the rest.
                endcase
            end
            OP_ORI: begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_wr  = 1'b1;
                ctrl.ext_op  = EXT_ZERO;
                ctrl.alu_op  = ALU_OR;
            end
            OP_LUI: begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_wr  = 1'b1;
                ctrl.ext_op  = EXT_UPPER;
                ctrl.alu_op  = ALU_LUI;
            end
            OP_LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = WB_MEM;
                ctrl.reg_wr     = 1'b1;
                ctrl.ext_op     = EXT_SIGN;
            end
            OP_SW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = WB_MEM;
                ctrl.mem_wr     = 1'b1;
                ctrl.ext_op     = EXT_SIGN;
            end
            OP_BEQ: begin
                ctrl.alu_op  = ALU_SUB;
                ctrl.npc_sel = zero ? NPC_BRANCH : NPC_PC4;  // taken on equal.
            end
            OP_J:    ctrl.npc_sel = NPC_JUMP;
            default: illegal = 1'b1;  // addi, addiu, jal and the rest.
        endcase
    end

endmodule

/* src/core.sv */
module core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    output bus_pkg::mem_req_s core_req,
    input  logic              core_gnt,
    input  logic [31:0]       rdata,
    input  mips_pkg::ctrl_s   ctrl,
    input  logic              illegal,
    output mips_pkg::opcode_e opcode,
    output mips_pkg::funct_e  funct,
    output logic              zero,
    output logic [4:0]        ra1,
    output logic [4:0]        ra2,
    output logic [4:0]        wa,
    output logic              we,
    output logic [31:0]       wd,
    input  logic [31:0]       rd1,
    input  logic [31:0]       rd2,
    output logic              halted
);
    import mips_pkg::*;
    import bus_pkg::*;

    typedef enum logic [1:0] {FETCH, EXEC, LOAD_WB, HALT} state_e;

    state_e         state;
    logic [31:0]    pc;
    logic [31:0]    ir;
    logic           ir_loaded;
    logic [15:0]    imm;
    logic [31:0]    ext_imm;
    logic [31:0]    alu_b;
    logic [31:0]    alu_result;
    logic [31:0]    pc_plus4;
    logic [31:0]    npc;
    logic           exec_ready;
    logic           mem_access;

    assign opcode = opcode_e'(ir[OP_LSB +: 6]);
    assign funct  = funct_e'(ir[5:0]);
    assign imm    = ir[IMM_W-1:0];
    assign ra1    = ir[RS_LSB +: 5];
    assign ra2    = ir[RT_LSB +: 5];
    assign wa     = (ctrl.reg_dst == DST_RD) ? ir[RD_LSB +: 5] : ir[RT_LSB +: 5];

    always_comb begin
        case (ctrl.ext_op)
            EXT_SIGN:  ext_imm = {{16{imm[15]}}, imm};
            EXT_UPPER: ext_imm = {imm, 16'h0000};
            default:   ext_imm = {16'h0000, imm};
        endcase
    end

    assign alu_b = ctrl.alu_src ? ext_imm : rd2;

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB: alu_result = rd1 - alu_b;
            ALU_OR:  alu_result = rd1 | alu_b;
            ALU_LUI: alu_result = alu_b;  // already shifted by the extender.
            default: alu_result = rd1 + alu_b;
        endcase
    end

    assign zero     = (alu_result == 32'd0);
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.npc_sel)
            NPC_BRANCH: npc = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
            NPC_JUMP:   npc = {pc_plus4[31:28], ir[TARGET_W-1:0], 2'b00};
            default:    npc = pc_plus4;
        endcase
    end

    assign exec_ready = (state == EXEC) && ir_loaded && !illegal;
    assign mem_access = (ctrl.mem_to_reg == WB_MEM);

    // lw writes back only from LOAD_WB.
    assign we     = ctrl.reg_wr && ((exec_ready && !mem_access) || state == LOAD_WB);
    assign wd     = mem_access ? rdata : alu_result;
    assign halted = (state == HALT);

    always_comb begin
        core_req       = '0;
        core_req.wdata = rd2;
        if (state == FETCH && run) begin
            core_req.valid = 1'b1;
            core_req.addr  = pc[MEM_ADDR_W+1:2];
        end else if (exec_ready && mem_access) begin
            core_req.valid = 1'b1;
            core_req.write = ctrl.mem_wr;
            core_req.addr  = alu_result[MEM_ADDR_W+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXEC && !ir_loaded) begin
            ir <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= FETCH;
            pc        <= '0;
            ir_loaded <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    ir_loaded <= 1'b0;
                    if (core_gnt) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (!ir_loaded) begin
                        ir_loaded <= 1'b1;
                    end else if (illegal) begin
                        state <= HALT;
                    end else if (!mem_access) begin
                        pc    <= npc;
                        state <= FETCH;
                    end else if (core_gnt) begin
                        if (ctrl.mem_wr) begin
                            pc    <= npc;
                            state <= FETCH;
                        end else begin
                            state <= LOAD_WB;
                        end
                    end
                end
                LOAD_WB: begin
                    pc    <= npc;
                    state <= FETCH;
                end
                default: state <= HALT;  // held until reset.
            endcase
        end
    end

endmodule

/* src/mem_arbiter.sv */
module mem_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::mem_req_s core_req,
    input  bus_pkg::mem_req_s apb_mem_req,
    output logic              core_gnt,
    output logic              apb_gnt,
    output bus_pkg::mem_req_s mem_req
);

    assign apb_gnt  = apb_mem_req.valid;
    assign core_gnt = core_req.valid && !apb_mem_req.valid;

    always_comb begin
        mem_req       = apb_gnt ? apb_mem_req : core_req;
        mem_req.valid = apb_gnt || core_gnt;
    end

endmodule

/* src/mips_pkg.sv */
package mips_pkg;

    // instruction field positions.
    localparam int OP_LSB   = 26;
    localparam int RS_LSB   = 21;
    localparam int RT_LSB   = 16;
    localparam int RD_LSB   = 11;
    localparam int IMM_W    = 16;
    localparam int TARGET_W = 26;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,  // not supported.
        OP_BEQ     = 6'b000100,
        OP_ADDI    = 6'b001000,  // not supported.
        OP_ADDIU   = 6'b001001,  // not supported.
        OP_ORI     = 6'b001101,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,     // not supported.
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_SLT  = 6'b101010      // not supported.
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_OR  = 3'b011,
        ALU_LUI = 3'b100
    } alu_op_e;

    localparam logic [1:0] DST_RT     = 2'b00;
    localparam logic [1:0] DST_RD     = 2'b01;
    localparam logic [1:0] WB_ALU     = 2'b00;
    localparam logic [1:0] WB_MEM     = 2'b01;
    localparam logic [1:0] NPC_PC4    = 2'b00;
    localparam logic [1:0] NPC_BRANCH = 2'b01;
    localparam logic [1:0] NPC_JUMP   = 2'b10;
    localparam logic [1:0] EXT_ZERO   = 2'b00;
    localparam logic [1:0] EXT_SIGN   = 2'b01;
    localparam logic [1:0] EXT_UPPER  = 2'b10;

    typedef struct packed {
        logic [1:0] reg_dst;
        logic       alu_src;
        logic [1:0] mem_to_reg;
        logic       reg_wr;
        logic       mem_wr;
        logic [1:0] npc_sel;
        logic [1:0] ext_op;
        alu_op_e    alu_op;
    } ctrl_s;

    // no writes, falls through to pc+4.
    localparam ctrl_s CTRL_NONE = '{
        reg_dst:    DST_RT,
        alu_src:    1'b0,
        mem_to_reg: WB_ALU,
        reg_wr:     1'b0,
        mem_wr:     1'b0,
        npc_sel:    NPC_PC4,
        ext_op:     EXT_ZERO,
        alu_op:     ALU_ADD
    };

endpackage

/* src/mips_top.sv */
module mips_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  bus_pkg::apb_req_s apb,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              halted
);
    import mips_pkg::*;
    import bus_pkg::*;

    mem_req_s    core_req;
    mem_req_s    apb_mem_req;
    mem_req_s    mem_req;
    logic        core_gnt;
    logic        apb_gnt;
    logic [31:0] rdata;
    ctrl_s       ctrl;
    logic        illegal;
    opcode_e     opcode;
    funct_e      funct;
    logic        zero;
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [4:0]  wa;
    logic        we;
    logic [31:0] wd;
    logic [31:0] rd1;
    logic [31:0] rd2;

    controller controller_inst (
        .opcode(opcode), .funct(funct), .zero(zero), .ctrl(ctrl), .illegal(illegal)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst_n(rst_n), .ra1(ra1), .ra2(ra2), .wa(wa), .we(we), .wd(wd),
        .rd1(rd1), .rd2(rd2)
    );

    core core_inst (
        .clk(clk), .rst_n(rst_n), .run(run), .core_req(core_req), .core_gnt(core_gnt),
        .rdata(rdata), .ctrl(ctrl), .illegal(illegal), .opcode(opcode), .funct(funct),
        .zero(zero), .ra1(ra1), .ra2(ra2), .wa(wa), .we(we), .wd(wd), .rd1(rd1),
        .rd2(rd2), .halted(halted)
    );

    mem_arbiter mem_arbiter_inst (
        .clk(clk), .rst_n(rst_n), .core_req(core_req), .apb_mem_req(apb_mem_req),
        .core_gnt(core_gnt), .apb_gnt(apb_gnt), .mem_req(mem_req)
    );

    word_memory word_memory_inst (.clk(clk), .mem_req(mem_req), .rdata(rdata));

    apb_port apb_port_inst (
        .clk(clk), .rst_n(rst_n), .apb(apb), .apb_mem_req(apb_mem_req),
        .apb_gnt(apb_gnt), .rdata(rdata), .prdata(prdata), .pready(pready)
    );

endmodule

/* src/reg_file.sv */
module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // $0 is never written, so it reads zero.
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

/* src/word_memory.sv */
module word_memory (
    input  logic              clk,
    input  bus_pkg::mem_req_s mem_req,
    output logic [31:0]       rdata
);
    import bus_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (mem_req.valid) begin
            if (mem_req.write) begin
                mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                rdata <= mem[mem_req.addr];  // valid the cycle after grant.
            end
        end
    end

endmodule

/* tb.f */
src/mips_pkg.sv
src/bus_pkg.sv
src/controller.sv
src/reg_file.sv
src/core.sv
src/mem_arbiter.sv
src/word_memory.sv
src/apb_port.sv
src/mips_top.sv
test/tb_top.sv

/* test/tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    import mips_pkg::*;
    import bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int RUN_LIMIT      = 400;   // cycles one program may take.
    localparam int APB_WAIT_LIMIT = 8;
    localparam int MODEL_STEPS    = 200;
    localparam logic [31:0] HALT_WORD = 32'hfc00_0000;  // opcode 111111.

    logic        clk;
    logic        rst_n;
    logic        run;
    apb_req_s    apb;
    logic [31:0] prdata;
    logic        pready;
    logic        halted;

    logic [31:0] model_mem [1024];
    logic [31:0] prog [$];
    logic [31:0] lfsr_state = 32'hd1e5dd79;
    string       cur_test = "startup";
    int          test_errs;
    int          total_errs;
    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt;

    mips_top mips_top_inst (
        .clk(clk), .rst_n(rst_n), .run(run), .apb(apb),
        .prdata(prdata), .pready(pready), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: simulation ran past %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit.
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_word(funct_e fn, logic [4:0] rs, logic [4:0] rt,
                                           logic [4:0] rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_word(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_word(opcode_e op, logic [25:0] target);
        return {op, target};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s: %s", cur_test, msg);
        test_errs++;
        total_errs++;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Error: %s %s expected %08h actual %08h", cur_test, what, exp, act);
        test_errs++;
        total_errs++;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            $display("%s: passed", cur_test);
            pass_cnt++;
        end else begin
            $display("%s: failed with %0d errors", cur_test, test_errs);
            fail_cnt++;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst_n = 1'b0;
        run   = 1'b0;
        apb   = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // setup cycle, then access cycles until pready.
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waits;
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = wr;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        @(negedge clk);
        apb.penable = 1'b1;
        waits = 0;
        #1;
        while (!pready && waits < APB_WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            waits++;
        end
        if (!pready)
            report_failure($sformatf("APB access to %03h never got pready", addr));
        rdata = prdata;
        @(negedge clk);
        apb = '0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
        model_mem[addr[11:2]] = data;
    endtask

    task automatic check_mem_word(input logic [11:0] addr, input string what);
        logic [31:0] act;
        apb_access(1'b0, addr, '0, act);
        word_check: assert (act === model_mem[addr[11:2]])
            else report_mismatch($sformatf("%s @%03h", what, addr), model_mem[addr[11:2]], act);
    endtask

    task automatic load_program();
        foreach (prog[i]) apb_write(12'(i * 4), prog[i]);
    endtask

    // instruction-level interpreter of the subset.
    task automatic model_run(output logic stopped);
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] ir;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        logic [31:0] npc;
        int          steps;
        foreach (regs[i]) regs[i] = '0;
        pc      = '0;
        stopped = 1'b0;
        steps   = 0;
        while (!stopped && steps < MODEL_STEPS) begin
            ir   = model_mem[pc[11:2]];
            a    = regs[ir[25:21]];
            b    = regs[ir[20:16]];
            sext = {{16{ir[15]}}, ir[15:0]};
            addr = a + sext;
            npc  = pc + 32'd4;
            case (ir[31:26])
                OP_SPECIAL: begin
                    if (ir[5:0] == FN_ADDU)
                        regs[ir[15:11]] = a + b;
                    else if (ir[5:0] == FN_SUBU)
                        regs[ir[15:11]] = a - b;
                    else
                        stopped = 1'b1;
                end
                OP_ORI:  regs[ir[20:16]] = a | {16'h0000, ir[15:0]};
                OP_LUI:  regs[ir[20:16]] = {ir[15:0], 16'h0000};
                OP_LW:   regs[ir[20:16]] = model_mem[addr[11:2]];
                OP_SW:   model_mem[addr[11:2]] = b;
                OP_BEQ:  npc = (a == b) ? npc + {sext[29:0], 2'b00} : npc;
                OP_J:    npc = {npc[31:28], ir[25:0], 2'b00};
                default: stopped = 1'b1;
            endcase
            regs[0] = '0;
            if (!stopped)
                pc = npc;
            steps++;
        end
    endtask

    task automatic run_program();
        logic exp_halt;
        int   cycles;
        load_program();
        model_run(exp_halt);
        @(negedge clk);
        run    = 1'b1;
        cycles = 0;
        while (!halted && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        run = 1'b0;
        if (!halted)
            report_failure($sformatf("core did not halt within %0d cycles", RUN_LIMIT));
        halt_check: assert (halted === exp_halt)
            else report_mismatch("halted", 32'(exp_halt), 32'(halted));
    endtask

    setup_no_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (apb.psel && !apb.penable) |-> !pready)
        else report_failure("pready was high in an APB setup phase");

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else report_failure("halted dropped without a reset");

    task automatic apb_round_trip();
        logic [11:0] addrs [8];
        begin_test("apb_round_trip");
        foreach (addrs[i]) begin
            addrs[i] = {10'(lfsr_take(10)), 2'b00};
            apb_write(addrs[i], lfsr_take(32));
        end
        foreach (addrs[i]) check_mem_word(addrs[i], "read back");
        finish_test();
    endtask

    task automatic arith_test();
        begin_test("arith_imm");
        reset_dut();
        apb_write(12'h408, 32'hdead_beef);  // overwritten by the store of $0.
        prog = {};
        prog.push_back(i_word(OP_ORI, 0, 1, 16'h1234));
        prog.push_back(i_word(OP_LUI, 0, 2, 16'habcd));
        prog.push_back(i_word(OP_ORI, 2, 2, 16'(lfsr_take(16))));
        prog.push_back(r_word(FN_ADDU, 1, 2, 3));
        prog.push_back(r_word(FN_SUBU, 1, 2, 4));
        prog.push_back(i_word(OP_ORI, 0, 0, 16'h5555));
        prog.push_back(i_word(OP_SW, 0, 3, 16'h0400));
        prog.push_back(i_word(OP_SW, 0, 4, 16'h0404));
        prog.push_back(i_word(OP_SW, 0, 0, 16'h0408));
        prog.push_back(i_word(OP_SW, 0, 2, 16'h040c));
        prog.push_back(HALT_WORD);
        run_program();
        for (int a = 12'h400; a <= 12'h40c; a += 4) check_mem_word(12'(a), "result");
        finish_test();
    endtask

    task automatic load_store_test();
        begin_test("load_store");
        reset_dut();
        for (int a = 12'h500; a <= 12'h50c; a += 4) apb_write(12'(a), lfsr_take(32));
        prog = {};
        prog.push_back(i_word(OP_LW, 0, 1, 16'h0500));
        prog.push_back(i_word(OP_LW, 0, 2, 16'h0504));
        prog.push_back(r_word(FN_ADDU, 1, 2, 3));
        prog.push_back(i_word(OP_SW, 0, 3, 16'h0600));
        prog.push_back(i_word(OP_LW, 0, 4, 16'h0600));   // same word as the store.
        prog.push_back(r_word(FN_SUBU, 4, 1, 5));
        prog.push_back(i_word(OP_SW, 0, 5, 16'h0604));
        prog.push_back(i_word(OP_ORI, 0, 6, 16'h0508));
        prog.push_back(i_word(OP_LW, 6, 7, 16'h0004));
        prog.push_back(i_word(OP_SW, 6, 7, 16'h0100));
        prog.push_back(i_word(OP_LW, 6, 8, 16'hfff8));   // negative offset.
        prog.push_back(i_word(OP_SW, 6, 8, 16'h0104));
        prog.push_back(HALT_WORD);
        run_program();
        for (int a = 12'h500; a <= 12'h50c; a += 4) check_mem_word(12'(a), "source");
        for (int a = 12'h600; a <= 12'h60c; a += 4) check_mem_word(12'(a), "stored");
        finish_test();
    endtask

    task automatic branch_test();
        begin_test("branch_jump");
        reset_dut();
        for (int a = 12'h700; a <= 12'h70c; a += 4) apb_write(12'(a), 32'd0);
        prog = {};
        prog.push_back(i_word(OP_ORI, 0, 1, 16'd5));
        prog.push_back(i_word(OP_ORI, 0, 2, 16'd5));
        prog.push_back(i_word(OP_ORI, 0, 3, 16'd7));
        prog.push_back(i_word(OP_ORI, 0, 9, 16'h00aa));   // marker.
        prog.push_back(i_word(OP_BEQ, 1, 2, 16'd1));      // taken.
        prog.push_back(i_word(OP_SW, 0, 9, 16'h0700));
        prog.push_back(i_word(OP_BEQ, 1, 3, 16'd1));      // not taken.
        prog.push_back(i_word(OP_SW, 0, 9, 16'h0704));
        prog.push_back(j_word(OP_J, 26'd10));
        prog.push_back(i_word(OP_SW, 0, 9, 16'h0708));
        prog.push_back(i_word(OP_SW, 0, 9, 16'h070c));
        prog.push_back(HALT_WORD);
        run_program();
        for (int a = 12'h700; a <= 12'h70c; a += 4) check_mem_word(12'(a), "marker");
        finish_test();
    endtask

    task automatic unsupported_test();
        logic [31:0] bad [5];
        begin_test("unsupported_halt");
        bad[0] = r_word(FN_SLT, 1, 1, 2);
        bad[1] = r_word(FN_JR, 1, 0, 0);
        bad[2] = i_word(OP_ADDI, 0, 2, 16'd5);
        bad[3] = i_word(OP_ADDIU, 0, 2, 16'd5);
        bad[4] = j_word(OP_JAL, 26'd4);
        foreach (bad[i]) begin
            reset_dut();
            apb_write(12'h800, lfsr_take(32));
            prog = {};
            prog.push_back(i_word(OP_ORI, 0, 1, 16'h0077));
            prog.push_back(bad[i]);
            prog.push_back(i_word(OP_SW, 0, 1, 16'h0800));
            prog.push_back(HALT_WORD);
            run_program();
            check_mem_word(12'h800, $sformatf("sentinel run %0d", i));
        end
        finish_test();
    endtask

    task automatic reset_state_test();
        begin_test("reset_state");
        apb_write(12'h900, lfsr_take(32));
        prog = {};
        prog.push_back(i_word(OP_ORI, 0, 1, 16'h0077));
        prog.push_back(i_word(OP_SW, 0, 1, 16'h0900));   // would overwrite the kept word.
        prog.push_back(HALT_WORD);
        load_program();
        reset_dut();
        #1;
        halt_low: assert (halted === 1'b0)
            else report_mismatch("halted after reset", 32'd0, 32'(halted));
        ready_low: assert (pready === 1'b0)
            else report_mismatch("pready after reset", 32'd0, 32'(pready));
        repeat (20) @(negedge clk);  // core idles with run low.
        check_mem_word(12'h900, "kept word");
        for (int a = 12'h700; a <= 12'h70c; a += 4) check_mem_word(12'(a), "kept marker");
        finish_test();
    endtask

    initial begin
        rst_n = 1'b0;
        run   = 1'b0;
        apb   = '0;
        foreach (model_mem[i]) model_mem[i] = '0;
        reset_dut();
        apb_round_trip();
        arith_test();
        load_store_test();
        branch_test();
        unsupported_test();
        reset_state_test();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && total_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
